// File: Bender.yml
package:
  name: mini_mcu

sources:
  - include_dirs:
      - design
    files:
      - design/mini_mcu_pkg.sv
      - design/bus_decode_stage.sv
      - design/ram_banks.sv
      - design/ao_peripheral.sv
      - design/gpio_peripheral.sv
      - design/bus_response_mux.sv
      - design/mini_mcu.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/mini_mcu_props.sv
      - tb/tb_mini_mcu.sv

// File: design/ao_peripheral.sv
/*
 * always-on registers: exit value/valid, boot select, scratch
 */
`timescale 1ns/1ps
`include "mini_mcu_settings.svh"

module ao_peripheral
  import mini_mcu_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   ao_sel_i,
  input  logic [`MCU_ADDR_W-3:0] req_addr_i,
  input  logic                   req_we_i,
  input  logic [`MCU_DATA_W-1:0] req_wdata_i,
  input  logic                   boot_select_i,
  output logic [`MCU_DATA_W-1:0] ao_rdata_o,
  output logic [`MCU_DATA_W-1:0] exit_value_o,
  output logic                   exit_valid_o
);

  ao_reg_e                reg_off;
  logic                   wr_en;
  logic [`MCU_DATA_W-1:0] scratch_q;
  logic [`MCU_DATA_W-1:0] rdata_d;

  assign reg_off = ao_reg_e'(req_addr_i[1:0]);
  assign wr_en   = ao_sel_i && req_we_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      exit_value_o <= '0;
      exit_valid_o <= 1'b0;
    end else if (wr_en) begin
      if (reg_off == AO_EXIT_VALUE) exit_value_o <= req_wdata_i;
      // sticky until reset
      if (reg_off == AO_EXIT_VALID && req_wdata_i[0]) exit_valid_o <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en && reg_off == AO_SCRATCH) scratch_q <= req_wdata_i;
  end

  always_comb begin
    rdata_d = '0;
    case (reg_off)
      AO_EXIT_VALUE: rdata_d = exit_value_o;
      AO_EXIT_VALID: rdata_d[0] = exit_valid_o;
      AO_BOOT_SEL:   rdata_d[0] = boot_select_i;
      AO_SCRATCH:    rdata_d = scratch_q;
      default:       rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (ao_sel_i) ao_rdata_o <= rdata_d;
  end

endmodule

// File: design/bus_decode_stage.sv
/*
 * request acceptance, address decode and request register
 */
`timescale 1ns/1ps
`include "mini_mcu_settings.svh"

module bus_decode_stage
  import mini_mcu_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    bus_req_i,
  output logic                    bus_gnt_o,
  input  logic [`MCU_ADDR_W-1:0]  bus_addr_i,
  input  logic                    bus_we_i,
  input  logic [`MCU_DATA_W/8-1:0] bus_be_i,
  input  logic [`MCU_DATA_W-1:0]  bus_wdata_i,
  output logic                    ram_sel_o,
  output logic                    ao_sel_o,
  output logic                    gpio_sel_o,
  output logic [`MCU_ADDR_W-3:0]  req_addr_o,
  output logic                    req_we_o,
  output logic [`MCU_DATA_W/8-1:0] req_be_o,
  output logic [`MCU_DATA_W-1:0]  req_wdata_o,
  output logic                    rsp_pending_o,
  output bus_target_e             rsp_target_o
);

  logic                   xfer;
  logic [`MCU_ADDR_W-1:0] ram_off;
  logic [`MCU_ADDR_W-1:0] ao_off;
  logic [`MCU_ADDR_W-1:0] gpio_off;
  bus_target_e            tgt_d;

  assign xfer = bus_req_i && bus_gnt_o;

  // offsets wrap below the base, so one compare per window
  assign ram_off  = bus_addr_i - `MCU_RAM_BASE;
  assign ao_off   = bus_addr_i - `MCU_AO_BASE;
  assign gpio_off = bus_addr_i - `MCU_GPIO_BASE;

  always_comb begin
    if (ram_off < `MCU_RAM_SPAN) tgt_d = TGT_RAM;
    else if (ao_off < `MCU_AO_SPAN) tgt_d = TGT_AO;
    else if (gpio_off < `MCU_GPIO_SPAN) tgt_d = TGT_GPIO;
    else tgt_d = TGT_NONE;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      bus_gnt_o     <= 1'b0;
      ram_sel_o     <= 1'b0;
      ao_sel_o      <= 1'b0;
      gpio_sel_o    <= 1'b0;
      rsp_pending_o <= 1'b0;
      rsp_target_o  <= TGT_NONE;
    end else begin
      // always ready once out of reset
      bus_gnt_o     <= 1'b1;
      ram_sel_o     <= xfer && (tgt_d == TGT_RAM);
      ao_sel_o      <= xfer && (tgt_d == TGT_AO);
      gpio_sel_o    <= xfer && (tgt_d == TGT_GPIO);
      rsp_pending_o <= xfer;
      if (xfer) rsp_target_o <= tgt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (xfer) begin
      req_addr_o  <= bus_addr_i[`MCU_ADDR_W-1:2];
      req_we_o    <= bus_we_i;
      req_be_o    <= bus_be_i;
      req_wdata_o <= bus_wdata_i;
    end
  end

endmodule

// File: design/bus_response_mux.sv
/*
 * response stage: aligns target info with read data, drives rvalid
 */
`timescale 1ns/1ps
`include "mini_mcu_settings.svh"

module bus_response_mux
  import mini_mcu_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   rsp_pending_i,
  input  bus_target_e            rsp_target_i,
  input  logic [`MCU_DATA_W-1:0] ram_rdata_i,
  input  logic [`MCU_DATA_W-1:0] ao_rdata_i,
  input  logic [`MCU_DATA_W-1:0] gpio_rdata_i,
  input  logic                   req_we_i,
  output logic                   bus_rvalid_o,
  output logic [`MCU_DATA_W-1:0] bus_rdata_o
);

  logic        pending_q;
  logic        we_q;
  bus_target_e target_q;

  // one stage, lines up with the registered target data
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q <= 1'b0;
      we_q      <= 1'b0;
      target_q  <= TGT_NONE;
    end else begin
      pending_q <= rsp_pending_i;
      we_q      <= req_we_i;
      target_q  <= rsp_target_i;
    end
  end

  assign bus_rvalid_o = pending_q;

  always_comb begin
    if (!pending_q || we_q) begin
      bus_rdata_o = '0;
    end else begin
      case (target_q)
        TGT_RAM:  bus_rdata_o = ram_rdata_i;
        TGT_AO:   bus_rdata_o = ao_rdata_i;
        TGT_GPIO: bus_rdata_o = gpio_rdata_i;
        default:  bus_rdata_o = `MCU_ERR_RDATA;
      endcase
    end
  end

endmodule

// File: design/gpio_peripheral.sv
/*
 * GPIO output and output-enable registers, synchronized input
 */
`timescale 1ns/1ps
`include "mini_mcu_settings.svh"

module gpio_peripheral
  import mini_mcu_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   gpio_sel_i,
  input  logic [`MCU_ADDR_W-3:0] req_addr_i,
  input  logic                   req_we_i,
  input  logic [`MCU_DATA_W-1:0] req_wdata_i,
  input  logic [`MCU_GPIO_W-1:0] gpio_i,
  output logic [`MCU_DATA_W-1:0] gpio_rdata_o,
  output logic [`MCU_GPIO_W-1:0] gpio_o,
  output logic [`MCU_GPIO_W-1:0] gpio_oe_o
);

  gpio_reg_e              reg_off;
  logic                   wr_en;
  logic [`MCU_GPIO_W-1:0] sync_q [2];
  logic [`MCU_DATA_W-1:0] rdata_d;

  assign reg_off = gpio_reg_e'(req_addr_i[1:0]);
  assign wr_en   = gpio_sel_i && req_we_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      gpio_o    <= '0;
      gpio_oe_o <= '0;
    end else if (wr_en) begin
      // GPIO_IN is read only
      if (reg_off == GPIO_OUT) gpio_o <= req_wdata_i[`MCU_GPIO_W-1:0];
      if (reg_off == GPIO_OE) gpio_oe_o <= req_wdata_i[`MCU_GPIO_W-1:0];
    end
  end

  // two-flop input synchronizer
  always_ff @(posedge clk_i) begin
    sync_q[0] <= gpio_i;
    sync_q[1] <= sync_q[0];
  end

  always_comb begin
    rdata_d = '0;
    case (reg_off)
      GPIO_OUT: rdata_d[`MCU_GPIO_W-1:0] = gpio_o;
      GPIO_OE:  rdata_d[`MCU_GPIO_W-1:0] = gpio_oe_o;
      GPIO_IN:  rdata_d[`MCU_GPIO_W-1:0] = sync_q[1];
      default:  rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (gpio_sel_i) gpio_rdata_o <= rdata_d;
  end

endmodule

// File: design/mini_mcu.sv
/*
 * top level: decode stage, RAM and peripheral targets, response stage
 */
`timescale 1ns/1ps
`include "mini_mcu_settings.svh"

module mini_mcu
  import mini_mcu_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     bus_req_i,
  output logic                     bus_gnt_o,
  input  logic [`MCU_ADDR_W-1:0]   bus_addr_i,
  input  logic                     bus_we_i,
  input  logic [`MCU_DATA_W/8-1:0] bus_be_i,
  input  logic [`MCU_DATA_W-1:0]   bus_wdata_i,
  output logic                     bus_rvalid_o,
  output logic [`MCU_DATA_W-1:0]   bus_rdata_o,
  input  logic                     boot_select_i,
  input  logic [`MCU_GPIO_W-1:0]   gpio_i,
  output logic [`MCU_GPIO_W-1:0]   gpio_o,
  output logic [`MCU_GPIO_W-1:0]   gpio_oe_o,
  output logic [`MCU_DATA_W-1:0]   exit_value_o,
  output logic                     exit_valid_o
);

  logic                     ram_sel;
  logic                     ao_sel;
  logic                     gpio_sel;
  logic [`MCU_ADDR_W-3:0]   req_addr;
  logic                     req_we;
  logic [`MCU_DATA_W/8-1:0] req_be;
  logic [`MCU_DATA_W-1:0]   req_wdata;
  logic                     rsp_pending;
  bus_target_e              rsp_target;
  logic [`MCU_DATA_W-1:0]   ram_rdata;
  logic [`MCU_DATA_W-1:0]   ao_rdata;
  logic [`MCU_DATA_W-1:0]   gpio_rdata;

  bus_decode_stage u_decode (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .bus_req_i    (bus_req_i),
    .bus_gnt_o    (bus_gnt_o),
    .bus_addr_i   (bus_addr_i),
    .bus_we_i     (bus_we_i),
    .bus_be_i     (bus_be_i),
    .bus_wdata_i  (bus_wdata_i),
    .ram_sel_o    (ram_sel),
    .ao_sel_o     (ao_sel),
    .gpio_sel_o   (gpio_sel),
    .req_addr_o   (req_addr),
    .req_we_o     (req_we),
    .req_be_o     (req_be),
    .req_wdata_o  (req_wdata),
    .rsp_pending_o(rsp_pending),
    .rsp_target_o (rsp_target)
  );

  ram_banks u_ram (
    .clk_i      (clk_i),
    .ram_sel_i  (ram_sel),
    .req_addr_i (req_addr),
    .req_we_i   (req_we),
    .req_be_i   (req_be),
    .req_wdata_i(req_wdata),
    .ram_rdata_o(ram_rdata)
  );

  ao_peripheral u_ao (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .ao_sel_i     (ao_sel),
    .req_addr_i   (req_addr),
    .req_we_i     (req_we),
    .req_wdata_i  (req_wdata),
    .boot_select_i(boot_select_i),
    .ao_rdata_o   (ao_rdata),
    .exit_value_o (exit_value_o),
    .exit_valid_o (exit_valid_o)
  );

  gpio_peripheral u_gpio (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .gpio_sel_i  (gpio_sel),
    .req_addr_i  (req_addr),
    .req_we_i    (req_we),
    .req_wdata_i (req_wdata),
    .gpio_i      (gpio_i),
    .gpio_rdata_o(gpio_rdata),
    .gpio_o      (gpio_o),
    .gpio_oe_o   (gpio_oe_o)
  );

  bus_response_mux u_rsp (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .rsp_pending_i(rsp_pending),
    .rsp_target_i (rsp_target),
    .ram_rdata_i  (ram_rdata),
    .ao_rdata_i   (ao_rdata),
    .gpio_rdata_i (gpio_rdata),
    .req_we_i     (req_we),
    .bus_rvalid_o (bus_rvalid_o),
    .bus_rdata_o  (bus_rdata_o)
  );

endmodule

// File: design/mini_mcu_pkg.sv
/*
 * bus target and peripheral register offset types
 */
package mini_mcu_pkg;

  // target picked by the address decoder
  typedef enum logic [1:0] {
    TGT_RAM  = 2'd0,
    TGT_AO   = 2'd1,
    TGT_GPIO = 2'd2,
    TGT_NONE = 2'd3
  } bus_target_e;

  // always-on block, word offsets 0x0 to 0xC
  typedef enum logic [1:0] {
    AO_EXIT_VALUE = 2'd0,
    AO_EXIT_VALID = 2'd1,
    AO_BOOT_SEL   = 2'd2,
    AO_SCRATCH    = 2'd3
  } ao_reg_e;

  // GPIO block, offset 0xC is unused and reads zero
  typedef enum logic [1:0] {
    GPIO_OUT = 2'd0,
    GPIO_OE  = 2'd1,
    GPIO_IN  = 2'd2
  } gpio_reg_e;

endpackage

// File: design/mini_mcu_settings.svh
/*
 * address map, bus widths, RAM banking and the unmapped-read word
 */
`ifndef MINI_MCU_SETTINGS_SVH
`define MINI_MCU_SETTINGS_SVH

// bus widths
`define MCU_DATA_W 32
`define MCU_ADDR_W 32

// banked RAM, word interleaved across banks
`define MCU_NUM_BANKS 2
`define MCU_BANK_WORDS 64
`define MCU_RAM_BASE 32'h0000_0000
`define MCU_RAM_SPAN (`MCU_NUM_BANKS * `MCU_BANK_WORDS * 4)

// peripheral windows, four word registers each
`define MCU_AO_BASE 32'h2000_0000
`define MCU_AO_SPAN 32'h0000_0010
`define MCU_GPIO_BASE 32'h2001_0000
`define MCU_GPIO_SPAN 32'h0000_0010
`define MCU_GPIO_W 32

// returned for reads that hit no target
`define MCU_ERR_RDATA 32'hBADC_AB1E

`endif

// File: design/ram_banks.sv
/*
 * word-interleaved RAM banks, byte-enable writes, registered reads
 */
`timescale 1ns/1ps
`include "mini_mcu_settings.svh"

module ram_banks (
  input  logic                     clk_i,
  input  logic                     ram_sel_i,
  input  logic [`MCU_ADDR_W-3:0]   req_addr_i,
  input  logic                     req_we_i,
  input  logic [`MCU_DATA_W/8-1:0] req_be_i,
  input  logic [`MCU_DATA_W-1:0]   req_wdata_i,
  output logic [`MCU_DATA_W-1:0]   ram_rdata_o
);

  localparam int unsigned BANK_BITS = $clog2(`MCU_NUM_BANKS);
  localparam int unsigned ROW_BITS  = $clog2(`MCU_BANK_WORDS);

  logic [BANK_BITS-1:0]   bank_idx;
  logic [ROW_BITS-1:0]    row;
  logic [BANK_BITS-1:0]   bank_sel_q;
  logic [`MCU_DATA_W-1:0] bank_rdata [`MCU_NUM_BANKS];

  // low word bits pick the bank, the rest the row
  assign bank_idx = req_addr_i[BANK_BITS-1:0];
  assign row      = req_addr_i[BANK_BITS +: ROW_BITS];

  for (genvar b = 0; b < `MCU_NUM_BANKS; b++) begin : g_bank
    logic [`MCU_DATA_W-1:0] mem [`MCU_BANK_WORDS];
    logic [`MCU_DATA_W-1:0] rdata_q;
    logic                   bank_hit;

    assign bank_hit = ram_sel_i && (bank_idx == BANK_BITS'(b));

    always_ff @(posedge clk_i) begin
      if (bank_hit) begin
        if (req_we_i) begin
          for (int i = 0; i < `MCU_DATA_W/8; i++) begin
            if (req_be_i[i]) mem[row][8*i +: 8] <= req_wdata_i[8*i +: 8];
          end
        end
        // read-before-write on the same word
        rdata_q <= mem[row];
      end
    end

    assign bank_rdata[b] = rdata_q;
  end

  always_ff @(posedge clk_i) begin
    if (ram_sel_i) bank_sel_q <= bank_idx;
  end

  assign ram_rdata_o = bank_rdata[bank_sel_q];

endmodule

// File: mini_mcu.f
+incdir+design
design/mini_mcu_pkg.sv
design/bus_decode_stage.sv
design/ram_banks.sv
design/ao_peripheral.sv
design/gpio_peripheral.sv
design/bus_response_mux.sv
design/mini_mcu.sv
tb/mini_mcu_props.sv
tb/tb_mini_mcu.sv

// File: tb/mini_mcu_props.sv
/*
 * handshake, response timing and exit flag assertions, bound into mini_mcu
 */
`timescale 1ns/1ps

module mini_mcu_props (
  input logic clk_i,
  input logic rst_i,
  input logic bus_req_i,
  input logic bus_gnt_o,
  input logic bus_rvalid_o,
  input logic exit_valid_o
);

  int unsigned fail_count = 0;

  // no grant while reset is applied
  a_gnt_in_reset: assert property (@(posedge clk_i) rst_i |=> !bus_gnt_o)
    else begin
      $error("bus_gnt_o high after a reset cycle");
      fail_count++;
    end

  // each transfer answered exactly two cycles later
  a_rvalid_delay: assert property (@(posedge clk_i) disable iff (rst_i)
    (bus_req_i && bus_gnt_o) |-> ##2 bus_rvalid_o)
    else begin
      $error("no bus_rvalid_o two cycles after a transfer");
      fail_count++;
    end

  // sticky until reset
  a_exit_sticky: assert property (@(posedge clk_i)
    ($past(exit_valid_o) && !$past(rst_i)) |-> exit_valid_o)
    else begin
      $error("exit_valid_o fell without reset");
      fail_count++;
    end

endmodule

bind mini_mcu mini_mcu_props u_props (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .bus_req_i   (bus_req_i),
  .bus_gnt_o   (bus_gnt_o),
  .bus_rvalid_o(bus_rvalid_o),
  .exit_valid_o(exit_valid_o)
);

// File: tb/mini_mcu_stimulus.txt
# T id | W addr be wdata | R addr expected_rdata | P boot_select gpio_in
# C exit_value exit_valid gpio_o gpio_oe   (all values hex except the test id)
T 1
C 00000000 0 00000000 00000000
T 2
W 00000010 f 11223344
W 00000010 5 aabbccdd
R 00000010 11bb33dd
W 00000020 f cafef00d
W 00000024 f 0badf00d
R 00000020 cafef00d
R 00000024 0badf00d
T 3
P 1 00000000
W 20000000 f 0000002a
W 20000004 f 00000001
W 20000004 f 00000000
C 0000002a 1 00000000 00000000
R 20000008 00000001
T 4
W 20010000 f 000000a5
W 20010004 f 000000ff
C 0000002a 1 000000a5 000000ff
P 1 12345678
R 20010008 12345678
T 5
R 20000010 badcab1e
W 10000010 f deadbeef
W 20000010 f 00000077
R 00000010 11bb33dd
C 0000002a 1 000000a5 000000ff

// File: tb/tb_mini_mcu.sv
/*
 * testbench for mini_mcu: file-driven bus transfers, pin settings
 * and output checks against expected values from the stimulus file
 */
`timescale 1ns/1ps
`include "mini_mcu_settings.svh"

module tb_mini_mcu;

  localparam int CLK_PERIOD  = 40;
  localparam int DRIVE_DELAY = 2;
  localparam     STIM_FILE   = "tb/mini_mcu_stimulus.txt";

  logic                     clk_i;
  logic                     rst_i;
  logic                     bus_req_i;
  logic                     bus_gnt_o;
  logic [`MCU_ADDR_W-1:0]   bus_addr_i;
  logic                     bus_we_i;
  logic [`MCU_DATA_W/8-1:0] bus_be_i;
  logic [`MCU_DATA_W-1:0]   bus_wdata_i;
  logic                     bus_rvalid_o;
  logic [`MCU_DATA_W-1:0]   bus_rdata_o;
  logic                     boot_select_i;
  logic [`MCU_GPIO_W-1:0]   gpio_i;
  logic [`MCU_GPIO_W-1:0]   gpio_o;
  logic [`MCU_GPIO_W-1:0]   gpio_oe_o;
  logic [`MCU_DATA_W-1:0]   exit_value_o;
  logic                     exit_valid_o;

  // one entry per accepted transfer, oldest first
  logic [`MCU_DATA_W-1:0] expect_q [$];

  int unsigned errors       = 0;
  int unsigned checks       = 0;
  int unsigned cycles       = 0;
  int unsigned cycle_limit  = 0;
  int unsigned test_id      = 0;
  int unsigned test_err0    = 0;
  int unsigned tests_passed = 0;
  int unsigned tests_failed = 0;

  mini_mcu u_mini_mcu (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD/2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      $display("Mismatch %s: got %h expected %h", name, got, expected);
      errors++;
    end
  endtask

  task automatic expect_fields(input logic [7:0] cmd, input int got, input int want);
    if (got != want) begin
      $display("stimulus command '%c' has %0d fields where %0d are needed", cmd, got, want);
      errors++;
    end
  endtask

  // responses come back in order, sampled mid-cycle
  always @(negedge clk_i) begin
    if (!rst_i && bus_rvalid_o) begin
      if (expect_q.size() == 0) begin
        $display("bus_rvalid_o seen with no transfer outstanding");
        errors++;
      end else begin
        check_value("bus_rdata_o", bus_rdata_o, expect_q.pop_front());
      end
    end
  end

  task automatic bus_transfer(input logic we, input logic [31:0] addr,
                              input logic [3:0] be, input logic [31:0] wdata,
                              input logic [31:0] expected);
    bus_req_i   = 1'b1;
    bus_we_i    = we;
    bus_addr_i  = addr;
    bus_be_i    = be;
    bus_wdata_i = wdata;
    @(negedge clk_i);
    while (!bus_gnt_o) @(negedge clk_i);
    // accepted at the coming rising edge, writes answer with zero
    expect_q.push_back(we ? 32'h0 : expected);
    @(posedge clk_i);
    #DRIVE_DELAY;
    bus_req_i = 1'b0;
  endtask

  task automatic wait_drain();
    while (expect_q.size() != 0) @(negedge clk_i);
    @(posedge clk_i);
    #DRIVE_DELAY;
  endtask

  task automatic close_test();
    wait_drain();
    if (test_id != 0) begin
      if (errors == test_err0) begin
        $display("test %0d passed", test_id);
        tests_passed++;
      end else begin
        $display("test %0d failed with %0d errors", test_id, errors - test_err0);
        tests_failed++;
      end
    end
  endtask

  task automatic skip_line(input int fd);
    int ch;
    ch = $fgetc(fd);
    while (ch != "\n" && ch != -1) ch = $fgetc(fd);
  endtask

  function automatic int count_lines(input int fd);
    int ch;
    int lines;
    lines = 0;
    ch = $fgetc(fd);
    while (ch != -1) begin
      if (ch == "\n") lines++;
      ch = $fgetc(fd);
    end
    return lines;
  endfunction

  task automatic run_stimulus(input int fd);
    logic [7:0]  cmd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    int          n;
    int          fields;
    while ($fscanf(fd, " %c", cmd) == 1) begin
      case (cmd)
        "#": skip_line(fd);
        "T": begin
          fields = $fscanf(fd, "%d", n);
          expect_fields(cmd, fields, 1);
          close_test();
          test_id   = n;
          test_err0 = errors;
        end
        "W": begin
          fields = $fscanf(fd, "%h %h %h", a, b, c);
          expect_fields(cmd, fields, 3);
          bus_transfer(1'b1, a, b[3:0], c, 32'h0);
        end
        "R": begin
          fields = $fscanf(fd, "%h %h", a, b);
          expect_fields(cmd, fields, 2);
          bus_transfer(1'b0, a, 4'h0, 32'h0, b);
        end
        "P": begin
          fields = $fscanf(fd, "%h %h", a, b);
          expect_fields(cmd, fields, 2);
          boot_select_i = a[0];
          gpio_i        = b;
          // let the input synchronizer settle
          repeat (3) @(posedge clk_i);
          #DRIVE_DELAY;
        end
        "C": begin
          fields = $fscanf(fd, "%h %h %h %h", a, b, c, d);
          expect_fields(cmd, fields, 4);
          wait_drain();
          check_value("exit_value_o", exit_value_o, a);
          check_value("exit_valid_o", {31'h0, exit_valid_o}, b);
          check_value("gpio_o", gpio_o, c);
          check_value("gpio_oe_o", gpio_oe_o, d);
        end
        default: begin
          $display("unknown command '%c' in stimulus file", cmd);
          errors++;
          skip_line(fd);
        end
      endcase
    end
    close_test();
  endtask

  initial begin
    int          fd;
    int unsigned assert_fails;
    rst_i         = 1'b1;
    bus_req_i     = 1'b0;
    bus_addr_i    = '0;
    bus_we_i      = 1'b0;
    bus_be_i      = '0;
    bus_wdata_i   = '0;
    boot_select_i = 1'b0;
    gpio_i        = '0;
    repeat (2) @(posedge clk_i);
    #DRIVE_DELAY;
    rst_i = 1'b0;

    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("could not open the stimulus file %s", STIM_FILE);
      errors++;
    end else begin
      cycle_limit = 8 * count_lines(fd) + 100;
      $fclose(fd);
      fd = $fopen(STIM_FILE, "r");
      run_stimulus(fd);
      $fclose(fd);
    end

    assert_fails = u_mini_mcu.u_props.fail_count;
    $display("%0d tests: %0d passed, %0d failed; %0d checks, %0d errors, %0d assertion failures",
             tests_passed + tests_failed, tests_passed, tests_failed, checks, errors,
             assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
